/* Makefile */
# Verilator build and run of the ULA testbench

VERILATOR ?= verilator
TOP       ?= ula_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

.PHONY: sim clean

# Build, run, then pass only if the run printed the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+include
source/ula_op_pkg.sv
source/ula_num_pkg.sv
source/ula_int_unit.sv
source/ula_denorm.sv
source/ula_norm.sv
source/ula_float_unit.sv
source/ula_result_stage.sv
source/ula_top.sv
bench/ula_checker.sv
bench/ula_tb.sv

/* bench/ula_cases.txt */
// Columns: opcode in1 in2 expected, all hex
// Float words are sign, 8-bit exponent, 23-bit mantissa
// Pass-through
00 12345678 cafebabe cafebabe
01 12345678 cafebabe 12345678
// Integer arithmetic, wrap and sign rules
02 7fffffff 00000001 80000000
02 fffffffe 00000005 00000003
04 fffffffd 00000007 ffffffeb
04 00012345 00001000 12345000
09 00000001 fffffff6 0000000a
09 80000000 fffffff6 fffffff6
0b 00000000 fffffff6 0000000a
0f 00000000 ffffff00 00000100
13 00000000 80000001 00000000
13 00000000 00000042 00000042
// Logic
1d f0f0ff00 3c3c0ff0 30300f00
1e f0f0ff00 3c3c0ff0 fcfcfff0
1f f0f0ff00 3c3c0ff0 ccccf0f0
20 00000000 3c3c0ff0 c3c3f00f
// Compares and shifts
26 ffffffff 00000001 00000001
28 ffffffff 00000001 00000000
2a 0000abcd 0000abcd 00000001
2b 00000003 00000004 00000030
2c 80000000 0000001f 00000001
2d 80000000 00000004 f8000000
// Float add, zero sum, int to float
03 01000010 80000004 77f00000
03 ff800100 00800003 f8780000
03 02800008 82800008 40000000
19 00000000 00000005 76500000
19 00000000 fffffffd f5e00000
// Float sign ops, float to int, compares
0d 00000000 01000010 81000010
11 00000000 f8780000 78780000
0a 80000000 01000010 81000010
0a 00000001 ff800100 7f800100
1b 00000000 81800005 ffffffd8
1b 00000000 7f000013 00000004
1b 00000000 ff800007 fffffffc
27 01000010 80000004 00000000
29 01000010 80000004 00000001
27 ff800100 00800003 00000001
29 ff800100 00800003 00000000

/* bench/ula_checker.sv */
// ULA response checker
// Queues the expected result of each accepted request and compares the response
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ula_op_pkg::ula_req_t   req,
	input  logic [`ULA_NUBITS-1:0] exp_result, // Goes with req
	input  ula_op_pkg::ula_rsp_t   rsp,
	output int                     value_errors,
	output int                     flow_errors,
	output int                     pending      // Requests not yet answered
);

import ula_op_pkg::*;

typedef struct packed {
	ula_opcode_e            op;
	logic [`ULA_NUBITS-1:0] value;
} expect_t;

expect_t exp_q[$];
logic    accepted; // Request taken at the previous edge
logic    started;  // Any request since reset

initial begin
	value_errors = 0;
	flow_errors  = 0;
	pending      = 0;
end

// ****************************************
// Compare at each rising edge
// ****************************************

always @(posedge clk) begin
	expect_t head;
	if (!rst_n) begin
		exp_q.delete();
		accepted = 1'b0;
		started  = 1'b0;
	end else begin
		if ($isunknown(rsp.valid)) begin
			$display("Response valid is unknown at %0t ns", $time);
			flow_errors++;
		end else if (rsp.valid && !accepted) begin
			$display("Response at %0t ns with no request pending", $time);
			flow_errors++;
		end else if (accepted && !rsp.valid) begin
			$display("No response at %0t ns for the request one cycle earlier", $time);
			flow_errors++;
			head = exp_q.pop_front(); // Drop it, keep the rest in order
		end else if (accepted) begin
			head = exp_q.pop_front();
			if (rsp.result !== head.value) begin
				$display("** Error: rsp.result op %h expected %h actual %h",
					head.op, head.value, rsp.result);
				value_errors++;
			end
		end else if (!started && rsp.result !== `ULA_NUBITS'(0)) begin
			// Reset value holds until the first request
			$display("** Error: rsp.result after reset expected %h actual %h",
				`ULA_NUBITS'(0), rsp.result);
			value_errors++;
		end
		if (req.valid) begin
			exp_q.push_back({req.op, exp_result});
			started = 1'b1;
		end
		accepted = req.valid;
	end
	pending = exp_q.size();
end

endmodule

`default_nettype wire

/* bench/ula_tb.sv */
// ULA testbench
// Reads the case file, drives requests in bursts and ends on the checker's counts
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_tb;

import ula_op_pkg::*;

localparam int MAX_CASES = 64;
localparam int WORDS     = 4; // op, in1, in2, expected
localparam int CLK_NS    = 8;
localparam int BURST     = 4; // Cases per back-to-back burst

logic                   clk;
logic                   rst_n;
ula_req_t               req;
ula_rsp_t               rsp;
logic [`ULA_NUBITS-1:0] exp_result;
logic [`ULA_NUBITS-1:0] case_mem [0:MAX_CASES*WORDS-1];
logic                   loaded;     // Case count known
int                     n_cases;
int                     bench_errors;
int                     value_errors;
int                     flow_errors;
int                     pending;

ula_top dut0 (
	.clk   (clk),
	.rst_n (rst_n),
	.req   (req),
	.rsp   (rsp)
);

ula_checker chk0 (
	.clk          (clk),
	.rst_n        (rst_n),
	.req          (req),
	.exp_result   (exp_result),
	.rsp          (rsp),
	.value_errors (value_errors),
	.flow_errors  (flow_errors),
	.pending      (pending)
);

initial clk = 1'b0;
always #(CLK_NS / 2) clk = ~clk;

// ****************************************
// Stimulus
// ****************************************

initial begin
	int idle;
	void'($urandom(88392));
	rst_n        = 1'b0;
	req          = '0;
	exp_result   = '0;
	loaded       = 1'b0;
	n_cases      = 0;
	bench_errors = 0;
	// Unread words get an opcode word no 6-bit opcode matches
	for (int i = 0; i < MAX_CASES * WORDS; i++) begin
		case_mem[i] = 32'hFFFF_0000 | i;
	end
	$readmemh("bench/ula_cases.txt", case_mem);
	while (n_cases < MAX_CASES && case_mem[n_cases*WORDS][31:6] == '0) begin
		n_cases++;
	end
	loaded = 1'b1;
	if (n_cases == 0) begin
		$display("No cases could be read from bench/ula_cases.txt");
		bench_errors++;
	end
	repeat (4) @(posedge clk);
	rst_n <= 1'b1;
	@(posedge clk); // One quiet cycle to see the reset value
	for (int c = 0; c < n_cases; c++) begin
		if (c != 0 && c % BURST == 0) begin
			idle = $urandom_range(1, 0); // Gap between bursts
			repeat (idle) begin
				@(posedge clk);
				req.valid <= 1'b0;
			end
		end
		@(posedge clk);
		req.valid  <= 1'b1;
		req.op     <= ula_opcode_e'(case_mem[c*WORDS][5:0]);
		req.in1    <= case_mem[c*WORDS+1];
		req.in2    <= case_mem[c*WORDS+2];
		exp_result <= case_mem[c*WORDS+3];
	end
	@(posedge clk);
	req.valid <= 1'b0;
	@(negedge clk);
	while (pending != 0) @(negedge clk); // Last responses drain
	repeat (2) @(posedge clk);
	$display("Errors: %0d value, %0d protocol, %0d bench",
		value_errors, flow_errors, bench_errors);
	if (value_errors + flow_errors + bench_errors == 0) begin
		$display("RESULT: PASS");
	end else begin
		$display("RESULT: FAIL");
	end
	$finish;
end

// Watchdog, scaled by the number of cases
initial begin
	wait (loaded);
	#((n_cases + 50) * CLK_NS);
	$display("Timeout, the run did not end within %0d cycles", n_cases + 50);
	$display("RESULT: FAIL");
	$finish;
end

endmodule

`default_nettype wire

/* include/ula_params.svh */
// ULA shared parameters
// Word, float field and opcode widths, and the result reset value
`ifndef ULA_PARAMS_SVH
`define ULA_PARAMS_SVH

// Data word
`define ULA_NUBITS    32
// Float fields, exponent in two's complement
`define ULA_NBMANT    23
`define ULA_NBEXPO    8
// Opcode field
`define ULA_NBOPCO    6
// Result register after reset
`define ULA_OUT_RESET 0

`endif

/* source/ula_denorm.sv */
// ULA float alignment
// Brings two floats to the larger exponent and applies their signs
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_denorm (
	input  ula_num_pkg::ula_word_u  in1,
	input  ula_num_pkg::ula_word_u  in2,
	output ula_num_pkg::ula_align_t align
);

localparam int MB = `ULA_NBMANT;
localparam int EB = `ULA_NBEXPO;

logic [EB:0]   eme;    // e1 - e2, extra bit so it cannot wrap
logic          ege;    // Set when e2 is the larger one
logic [EB:0]   shift1;
logic [EB:0]   shift2;
logic [MB-1:0] m1;
logic [MB-1:0] m2;

assign eme = {in1.fval.expo[EB-1], in1.fval.expo} - {in2.fval.expo[EB-1], in2.fval.expo};
assign ege = eme[EB];

// Only the smaller exponent side moves
assign shift1 = ege ? -eme : '0;
assign shift2 = ege ? '0 : eme;

assign m1 = in1.fval.mant >> shift1;
assign m2 = in2.fval.mant >> shift2;

always_comb begin
	align.expo = ege ? in2.fval.expo : in1.fval.expo;
	align.sm1  = in1.fval.sign ? -{1'b0, m1} : {1'b0, m1};
	align.sm2  = in2.fval.sign ? -{1'b0, m2} : {1'b0, m2};
end

endmodule

`default_nettype wire

/* source/ula_float_unit.sv */
// ULA float unit
// Add, sign ops, compares and int/float conversion on the native float format
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_float_unit (
	input  ula_op_pkg::ula_opcode_e op,
	input  ula_num_pkg::ula_word_u  in1,
	input  ula_num_pkg::ula_word_u  in2,
	output logic [`ULA_NUBITS-1:0]  result
);

import ula_op_pkg::*;
import ula_num_pkg::*;

localparam int MB = `ULA_NBMANT;
localparam int EB = `ULA_NBEXPO;

ula_align_t                    align;
ula_float_t                    fadd_w;
ula_float_t                    i2f_w;
ula_float_t                    norm_in;
ula_float_t                    norm_out;
logic signed [MB+1:0]          sum;     // Two guard bits over the mantissa
logic signed [MB+1:0]          sum_mag;
logic signed [MB-1:0]          i2f_v;
logic signed [MB:0]            f2i_sm;
logic signed [`ULA_NUBITS-1:0] f2i_ext;
logic signed [`ULA_NUBITS-1:0] f2i_w;
logic        [EB-1:0]          f2i_amt;
logic                          f_les;
logic                          f_gre;

ula_denorm u_denorm (
	.in1   (in1),
	.in2   (in2),
	.align (align)
);

// ****************************************
// F_ADD
// ****************************************

assign sum     = {align.sm1[MB], align.sm1} + {align.sm2[MB], align.sm2};
assign sum_mag = sum[MB+1] ? -sum : sum;

always_comb begin
	fadd_w.sign = sum[MB+1];
	fadd_w.expo = align.expo + EB'(1);  // Compensates the dropped low bit
	fadd_w.mant = sum_mag[MB:1];
end

// I2F, low mantissa-width bits of in2 as a signed int
assign i2f_v = in2.ival[MB-1:0];

always_comb begin
	i2f_w.sign = i2f_v[MB-1];
	i2f_w.expo = '0;
	i2f_w.mant = i2f_v[MB-1] ? -i2f_v : i2f_v;
end

// One normaliser, shared
assign norm_in = (op == OP_I2F) ? i2f_w : fadd_w;

ula_norm u_norm (
	.in  (norm_in),
	.out (norm_out)
);

// ****************************************
// F2I and compares
// ****************************************

assign f2i_sm  = in2.fval.sign ? -{1'b0, in2.fval.mant} : {1'b0, in2.fval.mant};
assign f2i_ext = f2i_sm;                                                   // Sign extend
assign f2i_amt = in2.fval.expo[EB-1] ? -in2.fval.expo : in2.fval.expo;     // |expo|
assign f2i_w   = in2.fval.expo[EB-1] ? (f2i_ext >>> f2i_amt) : (f2i_ext << f2i_amt);

assign f_les = $signed(align.sm1) < $signed(align.sm2);
assign f_gre = $signed(align.sm1) > $signed(align.sm2);

always_comb begin
	case (op)
		OP_F_ADD, OP_I2F: result = norm_out;
		OP_F_SGN: result = {in1.fval.sign, in2.fval.expo, in2.fval.mant}; // Sign taken from in1
		OP_F_NEG: result = {~in2.fval.sign, in2.fval.expo, in2.fval.mant};
		OP_F_ABS: result = {1'b0, in2.fval.expo, in2.fval.mant};
		OP_F_LES: result = `ULA_NUBITS'(f_les);
		OP_F_GRE: result = `ULA_NUBITS'(f_gre);
		OP_F2I:   result = f2i_w;
		default:  result = '0;
	endcase
end

endmodule

`default_nettype wire

/* source/ula_int_unit.sv */
// ULA integer unit
// Signed arithmetic, bitwise logic, compares and shifts, all combinational
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_int_unit (
	input  ula_op_pkg::ula_opcode_e op,
	input  logic [`ULA_NUBITS-1:0]  in1, // Memory
	input  logic [`ULA_NUBITS-1:0]  in2, // Accumulator
	output logic [`ULA_NUBITS-1:0]  result
);

import ula_op_pkg::*;

// Signed views of the operands
logic signed [`ULA_NUBITS-1:0] a;
logic signed [`ULA_NUBITS-1:0] b;

assign a = in1;
assign b = in2;

// ****************************************
// Result mux
// ****************************************

always_comb begin
	case (op)
		// Arithmetic, wraps on overflow
		OP_ADD: result = a + b;
		OP_MLT: result = a * b;                            // Low word only
		OP_SGN: result = (a[`ULA_NUBITS-1] == b[`ULA_NUBITS-1]) ? b : -b;

		// One operand, always in2
		OP_NEG: result = -b;
		OP_ABS: result = b[`ULA_NUBITS-1] ? -b : b;
		OP_PST: result = b[`ULA_NUBITS-1] ? '0 : b;      // Clamp negatives to 0

		OP_AND: result = in1 & in2;
		OP_ORR: result = in1 | in2;
		OP_XOR: result = in1 ^ in2;
		OP_INV: result = ~in2;

		// Compares give 1 or 0
		OP_LES: result = `ULA_NUBITS'(a < b);
		OP_GRE: result = `ULA_NUBITS'(a > b);
		OP_EQU: result = `ULA_NUBITS'(a == b);

		// Shift amount is the whole of in2
		OP_SHL: result = in1 << in2;
		OP_SHR: result = in1 >> in2;
		OP_SRS: result = a >>> in2;                        // Sign fill

		default: result = '0;
	endcase
end

endmodule

`default_nettype wire

/* source/ula_norm.sv */
// ULA float normaliser
// Moves the top set mantissa bit up to the MSB, adjusting the exponent
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_norm (
	input  ula_num_pkg::ula_float_t in,
	output ula_num_pkg::ula_float_t out
);

localparam int MB = `ULA_NBMANT;
localparam int EB = `ULA_NBEXPO;
localparam int SW = $clog2(MB);

logic [SW-1:0] sh; // Leading zeros, at most MB-1

// Leading zero count
// Scans upward so the highest set bit decides
always_comb begin
	sh = SW'(MB - 1);
	for (int i = 0; i < MB; i++) begin
		if (in.mant[i]) begin
			sh = SW'(MB - 1 - i);
		end
	end
end

always_comb begin
	out.sign = in.sign; // Kept even for zero
	out.mant = in.mant << sh;
	if (in.mant == '0) begin
		out.expo = {1'b1, {(EB-1){1'b0}}}; // Zero gets the most negative exponent
	end else begin
		out.expo = in.expo - EB'(sh);
	end
end

endmodule

`default_nettype wire

/* source/ula_num_pkg.sv */
// ULA number formats
// Float fields, int/float view of an operand word, aligned mantissa pair
`default_nettype none
`include "ula_params.svh"

package ula_num_pkg;

	// Value is (-1)^sign * mant * 2^expo, no hidden bit
	typedef struct packed {
		logic                          sign;
		logic signed [`ULA_NBEXPO-1:0] expo;
		logic        [`ULA_NBMANT-1:0] mant; // Plain unsigned integer
	} ula_float_t;

	// Same operand word, read as int or as float
	typedef union packed {
		logic signed [`ULA_NUBITS-1:0] ival;
		ula_float_t                    fval;
	} ula_word_u;

	// Both mantissas on the larger exponent
	typedef struct packed {
		logic signed [`ULA_NBEXPO-1:0] expo;
		logic signed [`ULA_NBMANT:0]   sm1;  // Sign applied, one bit wider
		logic signed [`ULA_NBMANT:0]   sm2;
	} ula_align_t;

endpackage

`default_nettype wire

/* source/ula_op_pkg.sv */
// ULA operation definitions
// Opcode list, result class and request and response bundles
`default_nettype none
`include "ula_params.svh"

package ula_op_pkg;

	// Gaps in the numbering are operations not built here
	typedef enum logic [`ULA_NBOPCO-1:0] {
		OP_NOP   = 6'd0,  OP_LOD   = 6'd1,                                    // Pass-through
		OP_ADD   = 6'd2,  OP_MLT   = 6'd4,  OP_SGN   = 6'd9,                  // Two-operand int
		OP_NEG   = 6'd11, OP_ABS   = 6'd15, OP_PST   = 6'd19,                 // One-operand int
		OP_AND   = 6'd29, OP_ORR   = 6'd30, OP_XOR   = 6'd31, OP_INV = 6'd32, // Bitwise
		OP_LES   = 6'd38, OP_GRE   = 6'd40, OP_EQU   = 6'd42,                 // Int compare
		OP_SHL   = 6'd43, OP_SHR   = 6'd44, OP_SRS   = 6'd45,                 // Shifts
		OP_F_ADD = 6'd3,  OP_F_SGN = 6'd10, OP_F_NEG = 6'd13, OP_F_ABS = 6'd17,
		OP_I2F   = 6'd25, OP_F2I   = 6'd27, OP_F_LES = 6'd39, OP_F_GRE = 6'd41
	} ula_opcode_e;

	// Where the registered result comes from
	typedef enum logic [1:0] {
		PASS_ACC, // in2 untouched
		PASS_MEM, // in1 untouched
		INT,
		FLOAT
	} ula_class_e;

	typedef struct packed {
		logic                   valid;
		ula_opcode_e            op;
		logic [`ULA_NUBITS-1:0] in1; // Memory operand
		logic [`ULA_NUBITS-1:0] in2; // Accumulator operand
	} ula_req_t;

	typedef struct packed {
		logic                   valid;
		logic [`ULA_NUBITS-1:0] result;
	} ula_rsp_t;

	function automatic ula_class_e op_class(ula_opcode_e op);
		case (op)
			OP_NOP: return PASS_ACC;
			OP_LOD: return PASS_MEM;
			OP_F_ADD, OP_F_SGN, OP_F_NEG, OP_F_ABS,
			OP_I2F, OP_F2I, OP_F_LES, OP_F_GRE: return FLOAT;
			default: return INT; // Int unit gives 0 on anything else
		endcase
	endfunction

	// Opcode has a result path in this build
	function automatic logic op_kept(ula_opcode_e op);
		return op inside {OP_NOP, OP_LOD, OP_ADD, OP_MLT, OP_SGN, OP_NEG, OP_ABS,
			OP_PST, OP_AND, OP_ORR, OP_XOR, OP_INV, OP_LES, OP_GRE, OP_EQU,
			OP_SHL, OP_SHR, OP_SRS, OP_F_ADD, OP_F_SGN, OP_F_NEG, OP_F_ABS,
			OP_I2F, OP_F2I, OP_F_LES, OP_F_GRE};
	endfunction

endpackage

`default_nettype wire

/* source/ula_result_stage.sv */
// ULA result stage
// Picks the result source by operation class and registers it with valid
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_result_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  ula_op_pkg::ula_req_t   req,
	input  logic [`ULA_NUBITS-1:0] int_result,
	input  logic [`ULA_NUBITS-1:0] float_result,
	output ula_op_pkg::ula_rsp_t   rsp
);

import ula_op_pkg::*;

logic [`ULA_NUBITS-1:0] sel; // Next result

always_comb begin
	case (op_class(req.op))
		PASS_ACC: sel = req.in2; // NOP
		PASS_MEM: sel = req.in1; // LOD
		INT:      sel = int_result;
		FLOAT:    sel = float_result;
	endcase
end

// Result holds its value between requests
always_ff @(posedge clk) begin
	if (!rst_n) begin
		rsp.valid  <= 1'b0;
		rsp.result <= `ULA_NUBITS'(`ULA_OUT_RESET);
	end else begin
		rsp.valid <= req.valid;
		if (req.valid) begin
			rsp.result <= sel;
		end
	end
end

// Requests only carry opcodes that both units and the mux know
a_op_kept: assert property (@(posedge clk) disable iff (!rst_n)
	req.valid |-> op_kept(req.op));

// Valid out of reset stays defined, whatever the sender does
a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
	!$isunknown(rsp.valid));

endmodule

`default_nettype wire

/* source/ula_top.sv */
// ULA top level
// Integer and float units feeding a one-cycle registered result
`timescale 1ns/1ps
`default_nettype none
`include "ula_params.svh"

module ula_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  ula_op_pkg::ula_req_t req,
	output ula_op_pkg::ula_rsp_t rsp
);

logic [`ULA_NUBITS-1:0] int_result;
logic [`ULA_NUBITS-1:0] float_result;

ula_int_unit u_int (
	.op     (req.op),
	.in1    (req.in1),
	.in2    (req.in2),
	.result (int_result)
);

ula_float_unit u_float (
	.op     (req.op),
	.in1    (req.in1),
	.in2    (req.in2),
	.result (float_result)
);

ula_result_stage u_result (
	.clk          (clk),
	.rst_n        (rst_n),
	.req          (req),
	.int_result   (int_result),
	.float_result (float_result),
	.rsp          (rsp)
);

endmodule

`default_nettype wire
